// ==== Bender.yml ====
package:
  name: fb_display

sources:
  - verilog/frame_pkg.sv
  - verilog/video_timing_gen.sv
  - verilog/frame_writer.sv
  - verilog/frame_reader.sv
  - verilog/mem_arbiter.sv
  - verilog/frame_memory.sv
  - verilog/pixel_unpacker.sv
  - verilog/fb_display_top.sv
  - target: test
    files:
      - test/fb_display_assertions.sv
      - test/tb_fb_display_top.sv

// ==== test/fb_display_assertions.sv ====
`timescale 1ns/1ps

module fb_display_assertions
    import frame_pkg::*;
(
    input logic     vtc_clk,
    input logic     rst_n_i,
    input pix_out_t pix_i,
    input mem_req_t wr_req_i,
    input mem_req_t rd_req_i,
    input logic     wr_grant_i,
    input logic     rd_grant_i,
    input logic     overflow_i,
    input logic     underflow_i
);

    int fail_cnt = 0;

    // active video never starts inside vsync
    de_outside_vsync: assert property (@(posedge vtc_clk) disable iff (!rst_n_i)
        $rose(pix_i.timing.de) |-> !pix_i.timing.vs)
    else begin
        $error("de rose while vs was high");
        fail_cnt = fail_cnt + 1;
    end

    // at most one grant and only to a requester holding its request
    grant_onehot0: assert property (@(posedge vtc_clk) disable iff (!rst_n_i)
        $onehot0({wr_grant_i, rd_grant_i}) &&
        (!wr_grant_i || wr_req_i.en) && (!rd_grant_i || rd_req_i.en))
    else begin
        $error("grant given twice or to a requester without a request");
        fail_cnt = fail_cnt + 1;
    end

    overflow_sticky: assert property (@(posedge vtc_clk) disable iff (!rst_n_i)
        overflow_i |=> overflow_i)
    else begin
        $error("overflow flag cleared without reset");
        fail_cnt = fail_cnt + 1;
    end

    underflow_sticky: assert property (@(posedge vtc_clk) disable iff (!rst_n_i)
        underflow_i |=> underflow_i)
    else begin
        $error("underflow flag cleared without reset");
        fail_cnt = fail_cnt + 1;
    end

endmodule

bind fb_display_top fb_display_assertions u_assertions (
    .vtc_clk     (vtc_clk),
    .rst_n_i     (rst_n_i),
    .pix_i       (pix_o),
    .wr_req_i    (wr_req),
    .rd_req_i    (rd_req),
    .wr_grant_i  (wr_grant),
    .rd_grant_i  (rd_grant),
    .overflow_i  (overflow_o),
    .underflow_i (underflow_o)
);

// ==== test/tb_fb_display_top.sv ====
`timescale 1ns/1ps

module tb_fb_display_top
    import frame_pkg::*;
();

    localparam int FRAME_CYCLES   = V_TOTAL * H_TOTAL;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES;      // tests span about 11.5 frames
    localparam int NUM_FRAMES     = 6;

    logic        vtc_clk;
    logic        rst_n_i;
    cam_word_t   cam;
    pix_out_t    pix;
    logic        overflow;
    logic        underflow;

    logic [31:0] lfsr_state;
    word_t       frames [NUM_FRAMES][FRAME_WORDS];
    int          cycle_cnt;

    fb_display_top uut (
        .vtc_clk     (vtc_clk),
        .rst_n_i     (rst_n_i),
        .cam_i       (cam),
        .pix_o       (pix),
        .overflow_o  (overflow),
        .underflow_o (underflow)
    );

    always #5 vtc_clk = ~vtc_clk;

    always @(posedge vtc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_pixel(input string name, input pixel_t exp_pix,
                                 input pixel_t act_pix);
        if (act_pix !== exp_pix) begin
            $display("mismatch %s: expected %02h, actual %02h", name, exp_pix, act_pix);
            abort_run();
        end
    endtask

    task automatic compare_timing(input string name, input timing_t exp_tim,
                                  input timing_t act_tim);
        if (act_tim !== exp_tim) begin
            $display("mismatch %s: expected vs/hs/de %03b, actual %03b", name, exp_tim, act_tim);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic exp_flag, input logic act_flag);
        if (act_flag !== exp_flag) begin
            $display("mismatch %s: expected %b, actual %b", name, exp_flag, act_flag);
            abort_run();
        end
    endtask

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic make_frames();
        word_t w;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < FRAME_WORDS; i++) begin
                w = '0;
                for (int b = 0; b < 32; b++) begin
                    lfsr_state = lfsr_next(lfsr_state);
                    w = {w[30:0], lfsr_state[0]};
                end
                frames[f][i] = w;
            end
        end
    endtask

    task automatic wait_vs_rise();
        @(negedge vtc_clk);
        while (pix.timing.vs) @(negedge vtc_clk);
        while (!pix.timing.vs) @(negedge vtc_clk);
    endtask

    // one word every two cycles with fs on word 0
    task automatic write_frame(input int idx);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            @(posedge vtc_clk);
            cam.fs    <= (i == 0);
            cam.valid <= 1'b1;
            cam.data  <= frames[idx][i];
            @(posedge vtc_clk);
            cam       <= '0;
        end
    endtask

    task automatic pulse_fs();
        @(posedge vtc_clk);
        cam.fs <= 1'b1;
        @(posedge vtc_clk);
        cam    <= '0;
    endtask

    task automatic capture_frame(input string name, input int idx);
        pixel_t exp_pix;
        word_t  w;
        for (int l = 0; l < V_ACTIVE; l++) begin
            @(negedge vtc_clk);
            while (!pix.timing.de) @(negedge vtc_clk);
            for (int p = 0; p < H_ACTIVE; p++) begin
                if (p != 0) begin
                    @(negedge vtc_clk);
                end
                w       = frames[idx][l * LINE_WORDS + p / PIX_PER_WORD];
                exp_pix = w[31 - 8 * (p % PIX_PER_WORD) -: 8];   // msb first
                compare_flag(name, 1'b1, pix.timing.de);
                compare_pixel(name, exp_pix, pix.pixel);
            end
            @(negedge vtc_clk);
            compare_flag(name, 1'b0, pix.timing.de);
        end
    endtask

    task automatic expect_idle_outputs(input string name);
        compare_timing(name, '0, pix.timing);
        compare_pixel(name, '0, pix.pixel);
        compare_flag(name, 1'b0, overflow);
        compare_flag(name, 1'b0, underflow);
    endtask

    task automatic reset_and_first_output();
        @(posedge vtc_clk);
        @(negedge vtc_clk);
        expect_idle_outputs("reset_and_first_output in reset");
        @(posedge vtc_clk);
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(negedge vtc_clk);
            expect_idle_outputs("reset_and_first_output after reset");
        end
    endtask

    task automatic timing_shape();
        timing_t exp_tim;
        int      h;
        int      v;
        h = 0;
        v = 0;
        @(negedge vtc_clk);                             // third cycle after reset is pixel 0
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (n != 0) begin
                @(negedge vtc_clk);
            end
            exp_tim.de = (h < H_ACTIVE) && (v < V_ACTIVE);
            exp_tim.hs = (h >= H_SYNC_START) && (h < H_SYNC_END);
            exp_tim.vs = (v >= V_SYNC_START) && (v < V_SYNC_END);
            compare_timing("timing_shape", exp_tim, pix.timing);
            h = h + 1;
            if (h == H_TOTAL) begin
                h = 0;
                v = v + 1;
            end
        end
    endtask

    task automatic one_frame_delay();
        wait_vs_rise();
        write_frame(0);
        pulse_fs();
        wait_vs_rise();
        capture_frame("one_frame_delay", 0);
    endtask

    task automatic buffer_rotation();
        wait_vs_rise();
        write_frame(1);
        wait_vs_rise();
        write_frame(2);
        wait_vs_rise();
        write_frame(3);
        capture_frame("buffer_rotation frame A", 1);
        wait_vs_rise();
        pulse_fs();
        capture_frame("buffer_rotation frame B", 2);
        wait_vs_rise();
        capture_frame("buffer_rotation frame C", 3);
    endtask

    task automatic concurrent_write_read();
        wait_vs_rise();
        write_frame(4);
        pulse_fs();
        wait_vs_rise();
        fork
            capture_frame("concurrent_write_read display", 4);
            begin
                @(negedge vtc_clk);
                while (!pix.timing.de) @(negedge vtc_clk);
                write_frame(5);                         // lands in the active lines
            end
        join
        compare_flag("concurrent_write_read overflow", 1'b0, overflow);
        compare_flag("concurrent_write_read underflow", 1'b0, underflow);
        pulse_fs();
        wait_vs_rise();
        capture_frame("concurrent_write_read next frame", 5);
    endtask

    initial begin
        vtc_clk    = 1'b0;
        rst_n_i    = 1'b0;
        cam        = '0;
        cycle_cnt  = 0;
        lfsr_state = 32'd90877;
        make_frames();
        reset_and_first_output();
        timing_shape();
        one_frame_delay();
        buffer_rotation();
        concurrent_write_read();
        if (uut.u_assertions.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", uut.u_assertions.fail_cnt);
            abort_run();
        end
    end

endmodule

// ==== verilog/fb_display_top.sv ====
`timescale 1ns/1ps

module fb_display_top
    import frame_pkg::*;
(
    input  logic      vtc_clk,
    input  logic      rst_n_i,
    input  cam_word_t cam_i,
    output pix_out_t  pix_o,
    output logic      overflow_o,
    output logic      underflow_o
);

    timing_t  timing;
    buf_idx_t wr_buf;
    mem_req_t wr_req;
    mem_req_t rd_req;
    mem_req_t mem_req;
    logic     wr_grant;
    logic     rd_grant;
    word_t    mem_rdata;
    logic     rd_valid;
    word_t    rd_data;
    logic     pop;
    word_t    rd_word;

    video_timing_gen u_timing (
        .vtc_clk  (vtc_clk),
        .rst_n_i  (rst_n_i),
        .timing_o (timing)
    );

    frame_writer u_writer (
        .vtc_clk    (vtc_clk),
        .rst_n_i    (rst_n_i),
        .cam_i      (cam_i),
        .req_o      (wr_req),
        .grant_i    (wr_grant),
        .wr_buf_o   (wr_buf),
        .overflow_o (overflow_o)
    );

    frame_reader u_reader (
        .vtc_clk     (vtc_clk),
        .rst_n_i     (rst_n_i),
        .timing_i    (timing),
        .wr_buf_i    (wr_buf),
        .req_o       (rd_req),
        .grant_i     (rd_grant),
        .rd_valid_i  (rd_valid),
        .rd_data_i   (rd_data),
        .pop_i       (pop),
        .word_o      (rd_word),
        .underflow_o (underflow_o)
    );

    mem_arbiter u_arbiter (
        .vtc_clk     (vtc_clk),
        .rst_n_i     (rst_n_i),
        .wr_req_i    (wr_req),
        .rd_req_i    (rd_req),
        .wr_grant_o  (wr_grant),
        .rd_grant_o  (rd_grant),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .rd_valid_o  (rd_valid),
        .rd_data_o   (rd_data)
    );

    frame_memory u_memory (
        .vtc_clk (vtc_clk),
        .req_i   (mem_req),
        .rdata_o (mem_rdata)
    );

    pixel_unpacker u_unpacker (
        .vtc_clk  (vtc_clk),
        .rst_n_i  (rst_n_i),
        .timing_i (timing),
        .pop_o    (pop),
        .word_i   (rd_word),
        .pix_o    (pix_o)
    );

endmodule

// ==== verilog/frame_memory.sv ====
`timescale 1ns/1ps

module frame_memory
    import frame_pkg::*;
(
    input  logic     vtc_clk,
    input  mem_req_t req_i,
    output word_t    rdata_o
);

    word_t mem [MEM_DEPTH];                             // three frames back to back

    always_ff @(posedge vtc_clk) begin
        if (req_i.en) begin
            if (req_i.we) begin
                mem[req_i.addr] <= req_i.wdata;
            end else begin
                rdata_o <= mem[req_i.addr];
            end
        end
    end

endmodule

// ==== verilog/frame_pkg.sv ====
package frame_pkg;

    // display timing shrunk for simulation
    localparam int H_ACTIVE      = 16;
    localparam int H_SYNC_START  = 20;
    localparam int H_SYNC_END    = 22;
    localparam int H_TOTAL       = 28;
    localparam int V_ACTIVE      = 4;
    localparam int V_SYNC_START  = 5;
    localparam int V_SYNC_END    = 6;
    localparam int V_TOTAL       = 8;

    // frame buffer layout
    localparam int PIX_PER_WORD  = 4;
    localparam int LINE_WORDS    = H_ACTIVE / PIX_PER_WORD;
    localparam int FRAME_WORDS   = LINE_WORDS * V_ACTIVE;
    localparam int BUF_NUM       = 3;
    localparam int BUF_DELAY     = 1;                   // reader trails writer by one buffer
    localparam int MEM_DEPTH     = BUF_NUM * FRAME_WORDS;
    localparam int WR_FIFO_DEPTH = 8;
    localparam int RD_FIFO_DEPTH = 8;

    // derived widths
    localparam int H_CNT_W       = $clog2(H_TOTAL);
    localparam int V_CNT_W       = $clog2(V_TOTAL);
    localparam int ADDR_W        = $clog2(MEM_DEPTH);
    localparam int WORD_IDX_W    = $clog2(FRAME_WORDS);
    localparam int BYTE_SEL_W    = $clog2(PIX_PER_WORD);
    localparam int WR_CNT_W      = $clog2(WR_FIFO_DEPTH) + 1;
    localparam int RD_CNT_W      = $clog2(RD_FIFO_DEPTH) + 1;

    typedef logic [31:0]       word_t;
    typedef logic [7:0]        pixel_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [1:0]        buf_idx_t;

    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } timing_t;

    typedef struct packed {
        logic  fs;                                      // frame start pulse
        logic  valid;
        word_t data;
    } cam_word_t;

    typedef struct packed {
        logic      en;
        logic      we;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        timing_t timing;
        pixel_t  pixel;
    } pix_out_t;

    typedef enum logic [1:0] {
        GRANT_NONE  = 2'd0,
        GRANT_READ  = 2'd1,
        GRANT_WRITE = 2'd2
    } arb_grant_e;

    typedef enum logic [1:0] {
        RD_IDLE      = 2'd0,
        RD_FETCH     = 2'd1,
        RD_WAIT_LINE = 2'd2
    } rd_state_e;

endpackage

// ==== verilog/frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader
    import frame_pkg::*;
(
    input  logic     vtc_clk,
    input  logic     rst_n_i,
    input  timing_t  timing_i,
    input  buf_idx_t wr_buf_i,
    output mem_req_t req_o,
    input  logic     grant_i,
    input  logic     rd_valid_i,
    input  word_t    rd_data_i,
    input  logic     pop_i,
    output word_t    word_o,
    output logic     underflow_o
);

    rd_state_e           state;
    logic                vs_q;
    logic                vs_rise;
    logic                armed;
    buf_idx_t            rd_buf;
    mem_addr_t           rd_addr;
    logic [WORD_IDX_W:0] words_left;
    logic [RD_CNT_W-1:0] in_flight;
    logic                issue;
    logic                space;

    word_t               fifo_mem [RD_FIFO_DEPTH];
    logic [RD_CNT_W-2:0] wr_ptr;
    logic [RD_CNT_W-2:0] rd_ptr;
    logic [RD_CNT_W-1:0] count;
    logic                empty;
    logic                push;
    logic                pop;
    logic                underflow;

    assign vs_rise = timing_i.vs && !vs_q;
    assign rd_buf  = buf_idx_t'((int'(wr_buf_i) + BUF_NUM - BUF_DELAY) % BUF_NUM);
    assign issue   = grant_i && (state == RD_FETCH);
    // reads already granted hold their FIFO slot
    assign space   = ({1'b0, count} + {1'b0, in_flight}) < (RD_CNT_W + 1)'(RD_FIFO_DEPTH);

    assign empty = (count == '0);
    assign push  = rd_valid_i;
    assign pop   = pop_i && !empty;

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= RD_IDLE;
            vs_q       <= 1'b0;
            armed      <= 1'b0;
            rd_addr    <= '0;
            words_left <= '0;
            in_flight  <= '0;
        end else begin
            vs_q      <= timing_i.vs;
            in_flight <= in_flight + RD_CNT_W'(issue) - RD_CNT_W'(rd_valid_i);
            if (vs_rise) begin
                armed      <= 1'b1;
                rd_addr    <= mem_addr_t'(rd_buf * FRAME_WORDS);
                words_left <= (WORD_IDX_W + 1)'(FRAME_WORDS);
                state      <= RD_WAIT_LINE;
            end else begin
                case (state)
                    RD_WAIT_LINE: begin
                        if ((words_left != '0) && space) begin
                            state <= RD_FETCH;
                        end
                    end
                    RD_FETCH: begin
                        if (grant_i) begin
                            rd_addr    <= rd_addr + 1'b1;
                            words_left <= words_left - 1'b1;
                            state      <= RD_WAIT_LINE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            underflow <= 1'b0;
        end else begin
            if (vs_rise) begin
                wr_ptr <= '0;                           // new frame starts clean
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + RD_CNT_W'(push) - RD_CNT_W'(pop);
            end
            if (pop_i && empty && armed) begin
                underflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= rd_data_i;
        end
        if (pop_i) begin
            word_o <= empty ? '0 : fifo_mem[rd_ptr];    // black on underrun
        end
    end

    always_comb begin
        req_o      = '0;
        req_o.en   = (state == RD_FETCH);
        req_o.addr = rd_addr;
    end

    assign underflow_o = underflow;

endmodule

// ==== verilog/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer
    import frame_pkg::*;
(
    input  logic      vtc_clk,
    input  logic      rst_n_i,
    input  cam_word_t cam_i,
    output mem_req_t  req_o,
    input  logic      grant_i,
    output buf_idx_t  wr_buf_o,
    output logic      overflow_o
);

    buf_idx_t              buf_cnt;
    buf_idx_t              next_buf;
    buf_idx_t              cur_buf;
    logic [WORD_IDX_W-1:0] word_cnt;
    logic [WORD_IDX_W-1:0] cur_word;
    mem_addr_t             push_addr;

    mem_addr_t             fifo_addr [WR_FIFO_DEPTH];
    word_t                 fifo_data [WR_FIFO_DEPTH];
    logic [WR_CNT_W-2:0]   wr_ptr;
    logic [WR_CNT_W-2:0]   rd_ptr;
    logic [WR_CNT_W-1:0]   count;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;
    logic                  overflow;

    assign next_buf  = (buf_cnt == buf_idx_t'(BUF_NUM - 1)) ? '0 : buf_cnt + 1'b1;
    assign cur_buf   = cam_i.fs ? next_buf : buf_cnt;   // fs word lands in the new buffer
    assign cur_word  = cam_i.fs ? '0 : word_cnt;
    assign push_addr = mem_addr_t'(cur_buf * FRAME_WORDS + cur_word);

    assign full  = (count == WR_CNT_W'(WR_FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = cam_i.valid && !full;
    assign pop   = grant_i && !empty;

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            buf_cnt  <= '0;
            word_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (cam_i.fs) begin
                buf_cnt <= next_buf;
            end
            if (cam_i.valid) begin
                word_cnt <= cur_word + 1'b1;
            end else if (cam_i.fs) begin
                word_cnt <= '0;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + WR_CNT_W'(push) - WR_CNT_W'(pop);
            if (cam_i.valid && full) begin
                overflow <= 1'b1;                       // sticky and the word is lost
            end
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (push) begin
            fifo_addr[wr_ptr] <= push_addr;
            fifo_data[wr_ptr] <= cam_i.data;
        end
    end

    // head of queue is held until granted
    always_comb begin
        req_o       = '0;
        req_o.en    = !empty;
        req_o.we    = 1'b1;
        req_o.addr  = fifo_addr[rd_ptr];
        req_o.wdata = fifo_data[rd_ptr];
    end

    assign wr_buf_o   = buf_cnt;
    assign overflow_o = overflow;

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import frame_pkg::*;
(
    input  logic     vtc_clk,
    input  logic     rst_n_i,
    input  mem_req_t wr_req_i,
    input  mem_req_t rd_req_i,
    output logic     wr_grant_o,
    output logic     rd_grant_o,
    output mem_req_t mem_req_o,
    input  word_t    mem_rdata_i,
    output logic     rd_valid_o,
    output word_t    rd_data_o
);

    arb_grant_e grant_q;
    arb_grant_e grant_d;
    logic       rd_valid_q;

    // read first but never the same requester twice in a row
    always_comb begin
        if (rd_req_i.en && (grant_q != GRANT_READ)) begin
            grant_d = GRANT_READ;
        end else if (wr_req_i.en && (grant_q != GRANT_WRITE)) begin
            grant_d = GRANT_WRITE;
        end else begin
            grant_d = GRANT_NONE;
        end
    end

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q    <= GRANT_NONE;
            rd_valid_q <= 1'b0;
        end else begin
            grant_q    <= grant_d;
            rd_valid_q <= (grant_q == GRANT_READ) && rd_req_i.en;   // matches ram latency
        end
    end

    always_comb begin
        case (grant_q)
            GRANT_READ:  mem_req_o = rd_req_i;
            GRANT_WRITE: mem_req_o = wr_req_i;
            default:     mem_req_o = '0;
        endcase
    end

    assign rd_grant_o = (grant_q == GRANT_READ);
    assign wr_grant_o = (grant_q == GRANT_WRITE);
    assign rd_valid_o = rd_valid_q;
    assign rd_data_o  = mem_rdata_i;

endmodule

// ==== verilog/pixel_unpacker.sv ====
`timescale 1ns/1ps

module pixel_unpacker
    import frame_pkg::*;
(
    input  logic     vtc_clk,
    input  logic     rst_n_i,
    input  timing_t  timing_i,
    output logic     pop_o,
    input  word_t    word_i,
    output pix_out_t pix_o
);

    logic [BYTE_SEL_W-1:0] byte_cnt;
    logic [BYTE_SEL_W-1:0] sel_q;
    timing_t               timing_q;
    pixel_t                byte_sel;

    // word arrives one cycle after the pop
    assign pop_o    = timing_i.de && (byte_cnt == '0);
    assign byte_sel = word_i[(PIX_PER_WORD - 1 - sel_q) * $bits(pixel_t) +: $bits(pixel_t)];

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            byte_cnt <= '0;
            sel_q    <= '0;
            timing_q <= '0;
            pix_o    <= '0;
        end else begin
            byte_cnt       <= timing_i.de ? byte_cnt + 1'b1 : '0;
            sel_q          <= byte_cnt;
            timing_q       <= timing_i;             // stage 1
            pix_o.timing   <= timing_q;             // stage 2
            pix_o.pixel    <= timing_q.de ? byte_sel : '0;
        end
    end

endmodule

// ==== verilog/video_timing_gen.sv ====
`timescale 1ns/1ps

module video_timing_gen
    import frame_pkg::*;
(
    input  logic    vtc_clk,
    input  logic    rst_n_i,
    output timing_t timing_o
);

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               line_end;
    logic               frame_end;

    assign line_end  = (h_cnt == H_CNT_W'(H_TOTAL - 1));
    assign frame_end = (v_cnt == V_CNT_W'(V_TOTAL - 1));

    always_ff @(posedge vtc_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (frame_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // active-high levels straight from the counters
    always_comb begin
        timing_o.de = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
        timing_o.hs = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
        timing_o.vs = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);   // whole lines
    end

endmodule

// ==== vlog.f ====
verilog/frame_pkg.sv
verilog/video_timing_gen.sv
verilog/frame_writer.sv
verilog/frame_reader.sv
verilog/mem_arbiter.sv
verilog/frame_memory.sv
verilog/pixel_unpacker.sv
verilog/fb_display_top.sv
test/fb_display_assertions.sv
test/tb_fb_display_top.sv
